/* src/m68k_bus_pkg.sv */
/*
 * External bus definitions for the 68000-style bus interface unit
 * Bus time slices, arbitration states, strobe and driver enable
 * groups, and the reset timing constants
 */
package m68k_bus_pkg;

   // ------------------------------------------------------------
   // Bus cycle timing
   // ------------------------------------------------------------

   // One slice per rising clock edge, S0 is the idle slice
   typedef enum logic [2:0] {
      S0, S1, S2, S3, S4, S5, S6, S7
   } slice_t;

   // Arbitration states, two-wire and three-wire masters
   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_GRANT,
      ARB_WAIT_RELEASE
   } arb_state_t;

   // Active-low bus strobes, all high while idle
   typedef struct packed {
      logic asn;
      logic udsn;
      logic ldsn;
      logic rwn;
   } bus_strobe_t;

   // Active-high three-state driver enables
   typedef struct packed {
      // Address and function code drivers
      logic adr_en;
      // Strobe drivers, off while another master owns the bus
      logic bus_drive_en;
      // Write data drivers, upper and lower byte lanes
      logic hi_byte_en;
      logic lo_byte_en;
   } drive_en_t;

   // ------------------------------------------------------------
   // Reset timing
   // ------------------------------------------------------------

   // Length of the reset command window in clocks
   localparam int RESET_OUT_CYCLES   = 124;
   // Consecutive low samples of the reset pin before CPU reset
   localparam int RESET_FILTER_LIMIT = 10;

   // Counter widths derived from the limits above
   localparam int RESET_TIMER_W  = $clog2(RESET_OUT_CYCLES + 1);
   localparam int RESET_FILTER_W = $clog2(RESET_FILTER_LIMIT + 1);

endpackage

/* src/m68k_core_pkg.sv */
/*
 * Core-side definitions for the bus interface unit
 * Bus request, receive buffer selects, operand size and data words
 */
package m68k_core_pkg;

   // Operand size of the current access
   typedef enum logic [1:0] {
      OP_BYTE,
      OP_WORD,
      OP_LONG
   } op_size_t;

   // Bus cycle request, held by the core until bus_cyc_rdy
   typedef struct packed {
      // Read and write requests, never both at once
      logic rd;
      logic wr;
      // Byte address bit, selects the odd lane when high
      logic a0;
      // Both byte lanes, word access
      logic byten_word;
   } bus_req_t;

   // Receive buffer half selects, priority in this order
   typedef struct packed {
      logic a_lo;
      logic a_hi;
      logic b_lo;
      logic b_hi;
   } buf_sel_t;

   // Data bus word and buffer long word
   typedef logic [15:0] word_t;
   typedef logic [31:0] long_t;

endpackage

/* src/bus_cycle_seq.sv */
/*
 * Bus cycle sequencer
 * Steps a read or write cycle through slices S0 to S7, holds S4 until
 * the slave acknowledges, samples bus error, and decodes the bus
 * strobes and driver enables as registered outputs
 */
module bus_cycle_seq
   import m68k_bus_pkg::*, m68k_core_pkg::*;
(
   input  logic        clk,
   input  logic        resetn,
   input  bus_req_t    req,
   input  logic        tas_lock,
   input  logic        bus_granted,
   input  logic        cpu_reset_active,
   input  logic        dtackn,
   input  logic        berrn,
   output bus_strobe_t strobes,
   output drive_en_t   drive_en,
   output logic        cycle_idle,
   output logic        bus_cyc_rdy,
   output logic        bus_err,
   output logic        data_valid,
   output logic        rx_load
);

   slice_t      slice;
   slice_t      slice_nxt;
   logic        req_any;
   logic        berr_now;
   logic        berr_seen;
   logic        wait_hold;
   logic        lane_hi;
   logic        lane_lo;
   logic        ds_window;
   bus_strobe_t strobes_nxt;
   drive_en_t   drive_en_nxt;

   assign req_any = req.rd | req.wr;

   // A pending request keeps the arbiter off at S0
   assign cycle_idle = (slice == S0) & ~req_any;

   // Bus error window is S3 to S6
   assign berr_now = ~berrn & (slice inside {[S3:S6]});

   // Wait state until DTACK, bus error or CPU reset
   assign wait_hold = dtackn & berrn & ~cpu_reset_active;

   // Byte lane selection, shared by strobes and data drivers
   assign lane_hi = ~req.a0 | req.byten_word;
   assign lane_lo = req.a0 | req.byten_word;

   // ------------------------------------------------------------
   // Slice counter
   // ------------------------------------------------------------
   always_comb
   begin
      case (slice)
         // Start only while nobody else owns the bus
         S0:      slice_nxt = (req_any & ~bus_granted) ? S1 : S0;
         S4:      slice_nxt = wait_hold ? S4 : S5;
         // Always back to S0, a held request restarts from there
         S7:      slice_nxt = S0;
         default: slice_nxt = slice_t'(slice + 3'd1);
      endcase
   end

   // ------------------------------------------------------------
   // Strobe and enable decode from the next slice
   // ------------------------------------------------------------
   always_comb
   begin
      // Read strobes from S2, write strobes wait for data at S4
      if (req.rd)
         ds_window = slice_nxt inside {[S2:S6]};
      else
         ds_window = req.wr & (slice_nxt inside {[S4:S6]});

      strobes_nxt.asn  = ~(slice_nxt inside {[S2:S6]});
      strobes_nxt.udsn = ~(ds_window & lane_hi);
      strobes_nxt.ldsn = ~(ds_window & lane_lo);
      // Write direction held through S7
      strobes_nxt.rwn  = ~(req.wr & (slice_nxt inside {[S2:S7]}));

      // Address stays driven across a locked read-modify-write
      drive_en_nxt.adr_en       = ~bus_granted &
                                  (tas_lock | (slice_nxt inside {[S1:S7]}));
      drive_en_nxt.bus_drive_en = ~bus_granted;
      drive_en_nxt.hi_byte_en   = req.wr & (slice_nxt inside {[S3:S7]}) & lane_hi;
      drive_en_nxt.lo_byte_en   = req.wr & (slice_nxt inside {[S3:S7]}) & lane_lo;
   end

   // ------------------------------------------------------------
   // State and output registers
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         slice       <= S0;
         berr_seen   <= 1'b0;
         strobes     <= '1;
         drive_en    <= '0;
         bus_cyc_rdy <= 1'b0;
         bus_err     <= 1'b0;
         data_valid  <= 1'b0;
         rx_load     <= 1'b0;
      end
      else
      begin
         slice <= slice_nxt;
         // Bus error sticks until the cycle returns to S0
         berr_seen <= (slice_nxt == S0) ? 1'b0 : (berr_seen | berr_now);

         strobes  <= strobes_nxt;
         drive_en <= drive_en_nxt;

         // End of cycle pulses, both in S7
         bus_cyc_rdy <= (slice_nxt == S7);
         bus_err     <= (slice_nxt == S7) & (berr_seen | berr_now);

         // Read data valid at S6 and S7
         data_valid <= req.rd & (slice_nxt inside {S6, S7});
         // Buffer load only for a clean read
         rx_load    <= req.rd & (slice_nxt == S7) & ~(berr_seen | berr_now);
      end
   end

endmodule

/* src/bus_arbiter.sv */
/*
 * Bus arbiter
 * Two-wire and three-wire arbitration, grants only between bus
 * cycles and never during a locked read-modify-write
 */
module bus_arbiter
   import m68k_bus_pkg::*;
(
   input  logic clk,
   input  logic resetn,
   input  logic brn,
   input  logic bgackn,
   input  logic tas_lock,
   input  logic cycle_idle,
   output logic bgn,
   output logic bus_granted
);

   arb_state_t state;
   arb_state_t state_nxt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ARB_IDLE:
            // No grant inside a cycle or a TAS lock
            if (~brn & cycle_idle & ~tas_lock)
               state_nxt = ARB_GRANT;
         ARB_GRANT:
            // Three-wire master takes over, or two-wire release
            if (~bgackn)
               state_nxt = ARB_WAIT_RELEASE;
            else if (brn)
               state_nxt = ARB_IDLE;
         ARB_WAIT_RELEASE:
            // On bgackn release a new request re-enters grant
            if (bgackn)
               state_nxt = brn ? ARB_IDLE : ARB_GRANT;
         default:
            state_nxt = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
         state <= ARB_IDLE;
      else
         state <= state_nxt;
   end

   // Grant pin low only in the grant state
   assign bgn = (state != ARB_GRANT);

   // Bus belongs to another master outside idle
   assign bus_granted = (state != ARB_IDLE);

endmodule

/* src/reset_ctrl.sv */
/*
 * Reset control
 * Filters the incoming reset pin into a CPU reset and times the
 * reset command output window with its ready strobe
 */
module reset_ctrl
   import m68k_bus_pkg::*;
(
   input  logic clk,
   input  logic resetn,
   input  logic reset_inn,
   input  logic reset_en,
   output logic reset_out_en,
   output logic reset_rdy,
   output logic reset_cpun,
   output logic cpu_reset_active
);

   logic [RESET_FILTER_W-1:0] filt_cnt;
   logic [RESET_FILTER_W-1:0] filt_nxt;
   logic [RESET_TIMER_W-1:0]  timer;
   logic                      timer_lock;

   // ------------------------------------------------------------
   // Reset pin filter
   // ------------------------------------------------------------
   always_comb
   begin
      // Count low samples, our own reset pulse does not count
      if (~reset_inn & ~reset_out_en)
      begin
         if (filt_cnt == RESET_FILTER_W'(RESET_FILTER_LIMIT))
            filt_nxt = filt_cnt;
         else
            filt_nxt = filt_cnt + 1'b1;
      end
      else
         filt_nxt = '0;
   end

   // ------------------------------------------------------------
   // Reset command timer
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         filt_cnt   <= '0;
         reset_cpun <= 1'b1;
         timer      <= '0;
         timer_lock <= 1'b0;
         reset_rdy  <= 1'b0;
      end
      else
      begin
         filt_cnt   <= filt_nxt;
         reset_cpun <= (filt_nxt != RESET_FILTER_W'(RESET_FILTER_LIMIT));

         // Load once per reset_en assertion
         if (reset_en & ~timer_lock)
         begin
            timer      <= RESET_TIMER_W'(RESET_OUT_CYCLES);
            timer_lock <= 1'b1;
         end
         else if (timer != '0)
            timer <= timer - 1'b1;
         else if (~reset_en)
            timer_lock <= 1'b0;

         // Ready strobe right after the last output cycle
         reset_rdy <= (timer == RESET_TIMER_W'(1));
      end
   end

   // Output window while the timer runs
   assign reset_out_en = (timer != '0);

   assign cpu_reset_active = ~reset_cpun;

endmodule

/* src/rx_buffer.sv */
/*
 * Receive buffers
 * Loads buffer A or B and the transparent data register from the
 * data bus at the end of a read cycle
 */
module rx_buffer
   import m68k_core_pkg::*;
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     rx_load,
   input  bus_req_t req,
   input  buf_sel_t buf_sel,
   input  op_size_t op_size,
   input  word_t    data_in,
   output long_t    buffer_a,
   output long_t    buffer_b,
   output word_t    data_core_out
);

   logic [7:0] rx_byte;
   logic       is_byte;

   // Even byte on the upper lane, odd byte on the lower lane
   assign rx_byte = req.a0 ? data_in[7:0] : data_in[15:8];
   assign is_byte = (op_size == OP_BYTE);

   // Low half load, a byte fills the whole buffer zero-extended
   function automatic long_t load_lo(long_t cur);
      if (is_byte)
         return {24'h000000, rx_byte};
      else
         return {cur[31:16], data_in};
   endfunction

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         buffer_a      <= '0;
         buffer_b      <= '0;
         data_core_out <= '0;
      end
      else if (rx_load)
      begin
         // One half per cycle, A before B, low before high
         if (buf_sel.a_lo)
            buffer_a <= load_lo(buffer_a);
         else if (buf_sel.a_hi)
            buffer_a[31:16] <= data_in;
         else if (buf_sel.b_lo)
            buffer_b <= load_lo(buffer_b);
         else if (buf_sel.b_hi)
            buffer_b[31:16] <= data_in;

         // Transparent register takes every read word
         data_core_out <= data_in;
      end
   end

endmodule

/* src/bus_interface.sv */
/*
 * 68000-style bus interface unit, top level
 * Connects the cycle sequencer, the arbiter, reset control and
 * the receive buffers
 */
module bus_interface
   import m68k_bus_pkg::*, m68k_core_pkg::*;
(
   input  logic        clk,
   input  logic        resetn,
   // Core side
   input  bus_req_t    req,
   input  logic        tas_lock,
   input  buf_sel_t    buf_sel,
   input  op_size_t    op_size,
   input  logic        reset_en,
   output logic        bus_cyc_rdy,
   output logic        bus_err,
   output logic        data_valid,
   output logic        reset_rdy,
   output logic        cpu_reset_active,
   output long_t       buffer_a,
   output long_t       buffer_b,
   output word_t       data_core_out,
   // Slave side
   input  word_t       data_in,
   input  logic        dtackn,
   input  logic        berrn,
   output bus_strobe_t strobes,
   output drive_en_t   drive_en,
   // Arbitration
   input  logic        brn,
   input  logic        bgackn,
   output logic        bgn,
   output logic        bus_granted,
   // Reset pin
   input  logic        reset_inn,
   output logic        reset_out_en,
   output logic        reset_cpun
);

   logic cycle_idle;
   logic rx_load;

   bus_cycle_seq u_seq (
      .clk              (clk),
      .resetn           (resetn),
      .req              (req),
      .tas_lock         (tas_lock),
      .bus_granted      (bus_granted),
      .cpu_reset_active (cpu_reset_active),
      .dtackn           (dtackn),
      .berrn            (berrn),
      .strobes          (strobes),
      .drive_en         (drive_en),
      .cycle_idle       (cycle_idle),
      .bus_cyc_rdy      (bus_cyc_rdy),
      .bus_err          (bus_err),
      .data_valid       (data_valid),
      .rx_load          (rx_load)
   );

   bus_arbiter u_arb (
      .clk         (clk),
      .resetn      (resetn),
      .brn         (brn),
      .bgackn      (bgackn),
      .tas_lock    (tas_lock),
      .cycle_idle  (cycle_idle),
      .bgn         (bgn),
      .bus_granted (bus_granted)
   );

   reset_ctrl u_rst (
      .clk              (clk),
      .resetn           (resetn),
      .reset_inn        (reset_inn),
      .reset_en         (reset_en),
      .reset_out_en     (reset_out_en),
      .reset_rdy        (reset_rdy),
      .reset_cpun       (reset_cpun),
      .cpu_reset_active (cpu_reset_active)
   );

   rx_buffer u_rxb (
      .clk           (clk),
      .resetn        (resetn),
      .rx_load       (rx_load),
      .req           (req),
      .buf_sel       (buf_sel),
      .op_size       (op_size),
      .data_in       (data_in),
      .buffer_a      (buffer_a),
      .buffer_b      (buffer_b),
      .data_core_out (data_core_out)
   );

endmodule

/* verif/bus_interface_chk.sv */
/*
 * Bus protocol assertions for the bus interface unit
 * Bound into the top level, checks request exclusivity, single-cycle
 * end strobes and that the grant never overlaps an address strobe
 */
module bus_interface_chk
   import m68k_bus_pkg::*, m68k_core_pkg::*;
(
   input logic        clk,
   input logic        resetn,
   input bus_req_t    req,
   input bus_strobe_t strobes,
   input logic        bus_cyc_rdy,
   input logic        bgn,
   input logic        reset_rdy
);
   timeunit 1ns;
   timeprecision 100ps;

   // Core never asks for a read and a write at once
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
      !(req.rd && req.wr))
      else $error("rd and wr requested together");

   // End of cycle strobe lasts one clock
   a_rdy_pulse: assert property (@(posedge clk) disable iff (!resetn)
      bus_cyc_rdy |=> !bus_cyc_rdy)
      else $error("bus_cyc_rdy longer than one cycle");

   // No grant while this unit drives the address strobe
   a_asn_no_grant: assert property (@(posedge clk) disable iff (!resetn)
      !strobes.asn |-> bgn)
      else $error("bgn low during asn");

   a_reset_rdy_pulse: assert property (@(posedge clk) disable iff (!resetn)
      reset_rdy |=> !reset_rdy)
      else $error("reset_rdy longer than one cycle");

endmodule

bind bus_interface bus_interface_chk u_chk (
   .clk         (clk),
   .resetn      (resetn),
   .req         (req),
   .strobes     (strobes),
   .bus_cyc_rdy (bus_cyc_rdy),
   .bgn         (bgn),
   .reset_rdy   (reset_rdy)
);

/* verif/tb_bus_interface.sv */
/*
 * Testbench for the 68000-style bus interface unit
 * Random read and write cycles against a slave model, bus error,
 * arbitration, reset command timing and reset pin filtering
 */
module tb_bus_interface
   import m68k_bus_pkg::*, m68k_core_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        resetn;
   bus_req_t    req;
   logic        tas_lock;
   buf_sel_t    buf_sel;
   op_size_t    op_size;
   logic        reset_en;
   word_t       data_in;
   logic        dtackn;
   logic        berrn;
   logic        brn;
   logic        bgackn;
   logic        reset_inn;
   logic        bus_cyc_rdy;
   logic        bus_err;
   logic        data_valid;
   logic        reset_rdy;
   logic        cpu_reset_active;
   long_t       buffer_a;
   long_t       buffer_b;
   word_t       data_core_out;
   bus_strobe_t strobes;
   drive_en_t   drive_en;
   logic        bgn;
   logic        bus_granted;
   logic        reset_out_en;
   logic        reset_cpun;

   // Slave model controls
   int          slave_delay;
   word_t       slave_data;
   logic        ack_en;
   logic        berr_en;
   int          asn_cnt;

   // Reference model of the receive buffers
   long_t       exp_a;
   long_t       exp_b;
   word_t       exp_dout;

   integer      seed;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_errs;

   // Single-bit outputs a wait loop can watch
   typedef enum {W_BGN, W_GRANTED, W_RST_OUT, W_CPUN} watch_t;

   bus_interface DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Slave model
   // ------------------------------------------------------------
   always @(posedge clk)
   begin
      if (!resetn || strobes.asn)
      begin
         dtackn  <= 1'b1;
         berrn   <= 1'b1;
         asn_cnt <= 0;
      end
      else
      begin
         asn_cnt <= asn_cnt + 1;
         // Acknowledge after slave_delay cycles of asn low
         if (ack_en && asn_cnt >= slave_delay)
         begin
            dtackn  <= 1'b0;
            data_in <= slave_data;
         end
         // Bus error lands inside the S3 to S6 window
         if (berr_en && asn_cnt >= 1)
            berrn <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // Helpers and compare tasks
   // ------------------------------------------------------------
   function automatic int rand_below(input int n);
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   function automatic logic watch(input watch_t w);
      case (w)
         W_BGN:     return bgn;
         W_GRANTED: return bus_granted;
         W_RST_OUT: return reset_out_en;
         default:   return reset_cpun;
      endcase
   endfunction

   task automatic check_long(input string name, input long_t want, input long_t act);
      checks++;
      if (act !== want)
      begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, want, act);
      end
   endtask

   task automatic check_word(input string name, input word_t want, input word_t act);
      checks++;
      if (act !== want)
      begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, want, act);
      end
   endtask

   task automatic check_strobe(input string name, input bus_strobe_t want,
                               input bus_strobe_t act);
      checks++;
      if (act !== want)
      begin
         errors++;
         $display("[FAIL] %s strobes expected %b actual %b", name, want, act);
      end
   endtask

   task automatic check_drive(input string name, input drive_en_t want,
                              input drive_en_t act);
      checks++;
      if (act !== want)
      begin
         errors++;
         $display("[FAIL] %s drive_en expected %b actual %b", name, want, act);
      end
   endtask

   task automatic check_bit(input string name, input logic want, input logic act);
      checks++;
      if (act !== want)
      begin
         errors++;
         $display("[FAIL] %s expected %b actual %b", name, want, act);
      end
   endtask

   task automatic check_count(input string name, input int want, input int act);
      checks++;
      if (act != want)
      begin
         errors++;
         $display("[FAIL] %s expected %0d actual %0d", name, want, act);
      end
   endtask

   // One line per finished test
   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_errs)
         tests_failed++;
      $display("test %s finished, %0d errors", name, errors - test_errs);
      test_errs = errors;
   endtask

   task automatic wait_sig(input string what, input watch_t w, input logic val,
                           input int limit);
      int n;
      n = 0;
      @(posedge clk);
      while (watch(w) !== val && n < limit)
      begin
         @(posedge clk);
         n++;
      end
      if (watch(w) !== val)
      begin
         errors++;
         $display("Timeout, %s did not reach %b within %0d cycles", what, val, limit);
      end
   endtask

   // Buffer rule, selected half with priority, byte zero-extended
   task automatic model_read(input bus_req_t r, input buf_sel_t s, input op_size_t o,
                             input word_t d);
      logic [7:0] bv;
      // Even byte rides on the upper data lines
      bv = r.a0 ? d[7:0] : d[15:8];
      if (s.a_lo)
         exp_a = (o == OP_BYTE) ? {24'h000000, bv} : {exp_a[31:16], d};
      else if (s.a_hi)
         exp_a[31:16] = d;
      else if (s.b_lo)
         exp_b = (o == OP_BYTE) ? {24'h000000, bv} : {exp_b[31:16], d};
      else if (s.b_hi)
         exp_b[31:16] = d;
      exp_dout = d;
   endtask

   // Runs one bus cycle and checks the strobes in every slice
   task automatic run_cycle(input string name, input bus_req_t r, input buf_sel_t s,
                            input op_size_t o, output logic err);
      int          n;
      logic        done;
      logic        in_asn;
      logic        ds_on;
      bus_strobe_t want;
      drive_en_t   want_en;
      n    = 0;
      done = 1'b0;
      err  = 1'b0;
      req     <= r;
      buf_sel <= s;
      op_size <= o;
      while (!done && n < 40)
      begin
         @(posedge clk);
         n++;
         // Sample 1 is S0, asn low from S2 until S7
         in_asn    = (n >= 3) && !bus_cyc_rdy;
         // Write data strobes wait for S4
         ds_on     = in_asn && (r.rd || n >= 5);
         want.asn  = ~in_asn;
         want.udsn = ~(ds_on && (!r.a0 || r.byten_word));
         want.ldsn = ~(ds_on && (r.a0 || r.byten_word));
         want.rwn  = ~(r.wr && n >= 3);
         check_strobe(name, want, strobes);
         // Address from S1, write data lanes from S3, both through S7
         want_en.adr_en       = (n >= 2);
         want_en.bus_drive_en = 1'b1;
         want_en.hi_byte_en   = r.wr && n >= 4 && (!r.a0 || r.byten_word);
         want_en.lo_byte_en   = r.wr && n >= 4 && (r.a0 || r.byten_word);
         check_drive(name, want_en, drive_en);
         // Read data valid at the end of a read, never on a write
         if (r.wr || bus_cyc_rdy)
            check_bit({name, " data_valid"}, r.rd && bus_cyc_rdy, data_valid);
         check_bit({name, " bgn"}, 1'b1, bgn);
         if (bus_cyc_rdy)
         begin
            done = 1'b1;
            err  = bus_err;
            req <= '0;
         end
      end
      if (!done)
      begin
         errors++;
         req <= '0;
         $display("Timeout, %s got no bus_cyc_rdy within 40 cycles", name);
      end
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial
   begin
      int       i;
      int       n;
      bus_req_t r;
      buf_sel_t s;
      op_size_t o;
      logic     err;
      seed         = 24;
      resetn       = 1'b0;
      req          = '0;
      tas_lock     = 1'b0;
      buf_sel      = '0;
      op_size      = OP_WORD;
      reset_en     = 1'b0;
      data_in      = '0;
      dtackn       = 1'b1;
      berrn        = 1'b1;
      brn          = 1'b1;
      bgackn       = 1'b1;
      reset_inn    = 1'b1;
      ack_en       = 1'b1;
      berr_en      = 1'b0;
      slave_delay  = 0;
      slave_data   = '0;
      asn_cnt      = 0;
      exp_a        = '0;
      exp_b        = '0;
      exp_dout     = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_errs    = 0;
      repeat (3) @(posedge clk);
      resetn <= 1'b1;
      @(posedge clk);

      // Random reads of random size into the buffers
      for (i = 0; i < 20; i++)
      begin
         o = op_size_t'(rand_below(3));
         r = '0;
         r.rd = 1'b1;
         r.byten_word = (o != OP_BYTE);
         r.a0 = (o == OP_BYTE) && (rand_below(2) != 0);
         s = buf_sel_t'(rand_below(16));
         slave_delay <= rand_below(5);
         slave_data  <= word_t'($random(seed));
         run_cycle("random_read", r, s, o, err);
         check_bit("random_read bus_err", 1'b0, err);
         model_read(r, s, o, slave_data);
         @(posedge clk);
         check_long("random_read buffer_a", exp_a, buffer_a);
         check_long("random_read buffer_b", exp_b, buffer_b);
         check_word("random_read data_core_out", exp_dout, data_core_out);
      end
      end_test("random_read");

      // Random writes, strobes checked slice by slice
      for (i = 0; i < 12; i++)
      begin
         r = '0;
         r.wr = 1'b1;
         r.byten_word = (rand_below(2) != 0);
         r.a0 = !r.byten_word && (rand_below(2) != 0);
         slave_delay <= rand_below(5);
         run_cycle("random_write", r, '0, OP_WORD, err);
         check_bit("random_write bus_err", 1'b0, err);
         @(posedge clk);
      end
      end_test("random_write");

      // Bus error with a slave that never acknowledges
      ack_en  <= 1'b0;
      berr_en <= 1'b1;
      // Fresh bus data so a wrong load would show in the buffers
      data_in <= ~exp_dout;
      r = '0;
      r.rd = 1'b1;
      r.byten_word = 1'b1;
      run_cycle("bus_error", r, buf_sel_t'(4'hf), OP_WORD, err);
      check_bit("bus_error bus_err", 1'b1, err);
      ack_en  <= 1'b1;
      berr_en <= 1'b0;
      @(posedge clk);
      check_long("bus_error buffer_a", exp_a, buffer_a);
      check_long("bus_error buffer_b", exp_b, buffer_b);
      check_word("bus_error data_core_out", exp_dout, data_core_out);
      end_test("bus_error");

      // Request during a cycle, grant only after it ends
      slave_delay <= 2;
      brn <= 1'b0;
      run_cycle("arb_cycle", r, '0, OP_WORD, err);
      model_read(r, '0, OP_WORD, slave_data);
      wait_sig("bgn after cycle", W_BGN, 1'b0, 8);
      brn <= 1'b1;
      wait_sig("bgn two-wire release", W_BGN, 1'b1, 8);
      check_bit("bus_granted two-wire", 1'b0, bus_granted);
      brn <= 1'b0;
      wait_sig("bgn three-wire grant", W_BGN, 1'b0, 8);
      bgackn <= 1'b0;
      brn    <= 1'b1;
      wait_sig("bgn under bgackn", W_BGN, 1'b1, 8);
      check_bit("bus_granted bgackn", 1'b1, bus_granted);
      // Strobe drivers released to the other master
      check_bit("bus_drive_en bgackn", 1'b0, drive_en.bus_drive_en);
      bgackn <= 1'b1;
      wait_sig("three-wire release", W_GRANTED, 1'b0, 8);
      // Locked read-modify-write keeps the bus
      tas_lock <= 1'b1;
      brn      <= 1'b0;
      for (i = 0; i < 12; i++)
      begin
         @(posedge clk);
         check_bit("bgn under tas_lock", 1'b1, bgn);
         if (i > 0)
            check_bit("adr_en under tas_lock", 1'b1, drive_en.adr_en);
      end
      brn      <= 1'b1;
      tas_lock <= 1'b0;
      @(posedge clk);
      end_test("arbitration");

      // Reset command window and ready pulse
      reset_en <= 1'b1;
      wait_sig("reset_out_en rise", W_RST_OUT, 1'b1, 8);
      n = 1;
      @(posedge clk);
      while (reset_out_en && n < 200)
      begin
         n++;
         @(posedge clk);
      end
      if (reset_out_en)
      begin
         errors++;
         $display("Timeout, reset_out_en stayed high for 200 cycles");
      end
      check_count("reset_out_en cycles", RESET_OUT_CYCLES, n);
      check_bit("reset_rdy pulse", 1'b1, reset_rdy);
      @(posedge clk);
      check_bit("reset_rdy length", 1'b0, reset_rdy);
      // reset_en still high, no second window
      repeat (20)
      begin
         @(posedge clk);
         check_bit("reset_out_en retrigger", 1'b0, reset_out_en);
      end
      reset_en <= 1'b0;
      @(posedge clk);
      end_test("reset_command");

      // Low pulse one sample short of the limit is filtered out
      reset_inn <= 1'b0;
      repeat (RESET_FILTER_LIMIT - 1)
      begin
         @(posedge clk);
         check_bit("reset_cpun short pulse", 1'b1, reset_cpun);
      end
      reset_inn <= 1'b1;
      repeat (4)
      begin
         @(posedge clk);
         check_bit("reset_cpun after pulse", 1'b1, reset_cpun);
      end
      reset_inn <= 1'b0;
      wait_sig("reset_cpun fall", W_CPUN, 1'b0, RESET_FILTER_LIMIT + 4);
      check_bit("cpu_reset_active set", 1'b1, cpu_reset_active);
      reset_inn <= 1'b1;
      wait_sig("reset_cpun rise", W_CPUN, 1'b1, 4);
      check_bit("cpu_reset_active clear", 1'b0, cpu_reset_active);
      end_test("reset_filter");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* compile.f */
src/m68k_bus_pkg.sv
src/m68k_core_pkg.sv
src/bus_cycle_seq.sv
src/bus_arbiter.sv
src/reset_ctrl.sv
src/rx_buffer.sv
src/bus_interface.sv
verif/bus_interface_chk.sv
verif/tb_bus_interface.sv
